//--- verilog/lcdPkg.sv
package lcdPkg;

	// ----------------------------------------------------------------------
	// byte kinds on the lcd bus
	// ----------------------------------------------------------------------

	typedef enum logic {
		kindCmd  = 1'b0,	// rs low.
		kindChar = 1'b1	// rs high.
	} lcdByteKind;

	typedef struct packed {
		lcdByteKind kind;
		logic [7:0] value;
	} lcdByte;

	// ----------------------------------------------------------------------
	// hd44780 command codes
	// ----------------------------------------------------------------------

	localparam logic [7:0] cmdFunctionSet = 8'h28;	// 4-bit bus, two lines, 5x8 font.
	localparam logic [7:0] cmdDisplayOn   = 8'h0C;	// display on, cursor off.
	localparam logic [7:0] cmdEntryMode   = 8'h06;	// increment, no shift.
	localparam logic [7:0] cmdClear       = 8'h01;
	localparam logic [7:0] cmdHome        = 8'h80;	// ddram address of line 1.

	// ----------------------------------------------------------------------
	// message table
	// ----------------------------------------------------------------------

	localparam int msgLength = 16;

	// first character of each string lands in element 0.
	localparam logic [0:1][0:msgLength-1][7:0] msgTable = '{
		"Hello, world!   ",
		"Next string here"
	};

endpackage

//--- verilog/lcdCmdIf.sv
`timescale 1ns/1ps

interface lcdCmdIf (
	input logic clk
);

	logic          valid;	// one cycle per byte, only with a credit held.
	lcdPkg::lcdByte payload;
	logic          credit;	// one pulse per free slot in the driver.
	logic          ready;	// init finished.

	modport sequencer (
		input  clk,
		output valid,
		output payload,
		input  credit,
		input  ready
	);

	modport driver (
		input  clk,
		input  valid,
		input  payload,
		output credit,
		output ready
	);

endinterface

//--- verilog/buttonSync.sv
`timescale 1ns/1ps

module buttonSync #(
	parameter int unsigned debounceCycles = 500000
) (
	input  logic clk,
	input  logic reset,
	input  logic button,
	output logic press
);

	localparam int cntWidth = $clog2(debounceCycles + 1);
	localparam logic [cntWidth-1:0] countLast = cntWidth'(debounceCycles - 1);

	logic                syncA;
	logic                syncB;
	logic                level;	// accepted, debounced level.
	logic                levelQ;
	logic [cntWidth-1:0] count;

	always_ff @(posedge clk) begin
		if (reset) begin
			syncA  <= 1'b0;
			syncB  <= 1'b0;
			level  <= 1'b0;
			levelQ <= 1'b0;
			count  <= '0;
			press  <= 1'b0;
		end else begin
			syncA  <= button;
			syncB  <= syncA;
			levelQ <= level;
			press  <= level & ~levelQ;	// one pulse per accepted rise.

			if (syncB == level) begin
				count <= '0;	// bounce back, start over.
			end else if (count == countLast) begin
				level <= syncB;
				count <= '0;
			end else begin
				count <= count + 1'b1;
			end
		end
	end

endmodule

//--- verilog/messageSequencer.sv
`timescale 1ns/1ps

module messageSequencer (
	input  logic clk,
	input  logic reset,
	input  logic clearAll,
	input  logic nextString,
	lcdCmdIf.sequencer link
);

	typedef enum logic [1:0] {
		reqNone,
		reqStart,	// first message after init, no toggle.
		reqNext,
		reqClear
	} reqKind;

	// step 0 is the clear, step 1 the home, then one step per character.
	localparam logic [4:0] lastStep = 5'(lcdPkg::msgLength + 1);

	reqKind     pending;
	reqKind     newReq;
	reqKind     request;
	logic       haveCredit;
	logic       creditAvail;
	logic       active;
	logic [4:0] step;
	logic       msgIndex;
	logic       readyQ;

	// ----------------------------------------------------------------------
	// byte for a list position
	// ----------------------------------------------------------------------

	function automatic lcdPkg::lcdByte byteFor(input logic [4:0] s, input logic idx);
		lcdPkg::lcdByte b;
		logic [4:0]     charPos;
		charPos = s - 5'd2;
		if (s == 5'd0) begin
			b.kind  = lcdPkg::kindCmd;
			b.value = lcdPkg::cmdClear;
		end else if (s == 5'd1) begin
			b.kind  = lcdPkg::kindCmd;
			b.value = lcdPkg::cmdHome;
		end else begin
			b.kind  = lcdPkg::kindChar;
			b.value = lcdPkg::msgTable[idx][charPos[3:0]];
		end
		return b;
	endfunction

	// ----------------------------------------------------------------------
	// request selection
	// ----------------------------------------------------------------------

	always_comb begin
		if (nextString) begin
			newReq = reqNext;	// a fresh press replaces an older one.
		end else if (clearAll) begin
			newReq = reqClear;
		end else if (link.ready && !readyQ) begin
			newReq = reqStart;
		end else begin
			newReq = reqNone;
		end
	end

	assign request     = (newReq != reqNone) ? newReq : pending;
	assign creditAvail = haveCredit | link.credit;

	// ----------------------------------------------------------------------
	// list walker
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			pending    <= reqNone;
			haveCredit <= 1'b0;
			active     <= 1'b0;
			step       <= '0;
			msgIndex   <= 1'b0;
			readyQ     <= 1'b0;
			link.valid <= 1'b0;
		end else begin
			readyQ     <= link.ready;
			link.valid <= 1'b0;

			if (link.credit) begin
				haveCredit <= 1'b1;
			end
			if (newReq != reqNone) begin
				pending <= newReq;	// held until the running list ends.
			end

			if (active && creditAvail) begin
				link.valid   <= 1'b1;
				link.payload <= byteFor(step, msgIndex);
				haveCredit   <= 1'b0;
				if (step == lastStep) begin
					active <= 1'b0;
				end else begin
					step <= step + 1'b1;
				end
			end else if (!active && request != reqNone && creditAvail) begin
				// every list opens with a clear.
				link.valid   <= 1'b1;
				link.payload <= byteFor(5'd0, msgIndex);
				haveCredit   <= 1'b0;
				pending      <= reqNone;
				active       <= (request != reqClear);
				step         <= 5'd1;
				if (request == reqNext) begin
					msgIndex <= ~msgIndex;
				end
			end
		end
	end

endmodule

//--- verilog/lcdNibbleDriver.sv
`timescale 1ns/1ps

module lcdNibbleDriver #(
	parameter int unsigned powerOnCycles   = 750000,
	parameter int unsigned setupCycles     = 2,
	parameter int unsigned enableCycles    = 12,
	parameter int unsigned shortWaitCycles = 2000,
	parameter int unsigned longWaitCycles  = 82000
) (
	input  logic       clk,
	input  logic       reset,
	lcdCmdIf.driver    link,
	output logic       lcdRs,
	output logic       lcdRw,
	output logic       lcdE,
	output logic [3:0] lcdData
);

	typedef enum logic [2:0] {
		stPowerOn,
		stSetup,
		stEnableHigh,
		stEnableLow,
		stWait,
		stIdle
	} drvState;

	drvState        state;
	logic [31:0]    count;
	logic [31:0]    phaseLen;
	logic           phaseDone;
	logic           waitLong;
	logic [2:0]     initStep;	// 0..3 nibbles, 4..7 full bytes.
	logic           halfOnly;	// init nibble, no low half.
	logic           nibbleLow;
	lcdPkg::lcdByte curByte;
	lcdPkg::lcdByte nextInit;

	// ----------------------------------------------------------------------
	// power-on init list
	// ----------------------------------------------------------------------

	function automatic lcdPkg::lcdByte initItem(input logic [2:0] s);
		lcdPkg::lcdByte b;
		b.kind = lcdPkg::kindCmd;
		case (s)
			3'd0, 3'd1, 3'd2: b.value = 8'h03;
			3'd3:             b.value = 8'h02;	// switch to 4-bit bus.
			3'd4:             b.value = lcdPkg::cmdFunctionSet;
			3'd5:             b.value = lcdPkg::cmdDisplayOn;
			3'd6:             b.value = lcdPkg::cmdEntryMode;
			default:          b.value = lcdPkg::cmdClear;
		endcase
		return b;
	endfunction

	assign nextInit = initItem(initStep + 3'd1);

	// ----------------------------------------------------------------------
	// phase length per state
	// ----------------------------------------------------------------------

	assign waitLong = halfOnly ||
		(curByte.kind == lcdPkg::kindCmd && curByte.value == lcdPkg::cmdClear);

	always_comb begin
		case (state)
			stPowerOn:    phaseLen = powerOnCycles;
			stSetup:      phaseLen = setupCycles;
			stEnableHigh: phaseLen = enableCycles;
			stEnableLow:  phaseLen = enableCycles;
			stWait:       phaseLen = waitLong ? longWaitCycles : shortWaitCycles;
			default:      phaseLen = 32'd1;
		endcase
	end

	assign phaseDone = (count == phaseLen - 32'd1);
	assign lcdRw     = 1'b0;	// write only, busy flag never read.

	// ----------------------------------------------------------------------
	// sequencer of pins
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= stPowerOn;
			count       <= '0;
			initStep    <= '0;
			halfOnly    <= 1'b0;
			nibbleLow   <= 1'b0;
			lcdRs       <= 1'b0;
			lcdE        <= 1'b0;
			lcdData     <= 4'h0;
			link.ready  <= 1'b0;
			link.credit <= 1'b0;
		end else begin
			link.credit <= 1'b0;

			if (state == stIdle || phaseDone) begin
				count <= '0;
			end else begin
				count <= count + 32'd1;
			end

			case (state)
				stPowerOn: begin
					if (phaseDone) begin
						lcdRs    <= 1'b0;
						lcdData  <= 4'h3;	// first init nibble.
						halfOnly <= 1'b1;
						state    <= stSetup;
					end
				end
				stSetup: begin
					if (phaseDone) begin
						lcdE  <= 1'b1;
						state <= stEnableHigh;
					end
				end
				stEnableHigh: begin
					if (phaseDone) begin
						lcdE  <= 1'b0;	// data latched on this fall.
						state <= stEnableLow;
					end
				end
				stEnableLow: begin
					if (phaseDone) begin
						if (halfOnly || nibbleLow) begin
							state <= stWait;
						end else begin
							nibbleLow <= 1'b1;
							lcdData   <= curByte.value[3:0];
							state     <= stSetup;
						end
					end
				end
				stWait: begin
					if (phaseDone) begin
						if (link.ready) begin
							link.credit <= 1'b1;
							state       <= stIdle;
						end else if (initStep == 3'd7) begin
							link.ready  <= 1'b1;	// stays high from here on.
							link.credit <= 1'b1;
							state       <= stIdle;
						end else begin
							initStep  <= initStep + 3'd1;
							lcdRs     <= 1'b0;
							nibbleLow <= 1'b0;
							curByte   <= nextInit;
							state     <= stSetup;
							if (initStep < 3'd3) begin
								halfOnly <= 1'b1;
								lcdData  <= nextInit.value[3:0];
							end else begin
								halfOnly <= 1'b0;
								lcdData  <= nextInit.value[7:4];
							end
						end
					end
				end
				default: begin
					if (link.valid) begin
						curByte   <= link.payload;
						lcdRs     <= (link.payload.kind == lcdPkg::kindChar);
						lcdData   <= link.payload.value[7:4];
						halfOnly  <= 1'b0;
						nibbleLow <= 1'b0;
						state     <= stSetup;
					end
				end
			endcase
		end
	end

endmodule

//--- verilog/lcdTop.sv
`timescale 1ns/1ps

module lcdTop #(
	parameter int unsigned debounceCycles  = 500000,
	parameter int unsigned powerOnCycles   = 750000,
	parameter int unsigned setupCycles     = 2,
	parameter int unsigned enableCycles    = 12,
	parameter int unsigned shortWaitCycles = 2000,
	parameter int unsigned longWaitCycles  = 82000
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       clearAll,
	input  logic       nextString,
	output logic       lcdRs,
	output logic       lcdRw,
	output logic       lcdE,
	output logic [3:0] lcdData
);

	logic clearPress;
	logic nextPress;

	lcdCmdIf link (.clk(clk));

	buttonSync #(.debounceCycles(debounceCycles)) clearSync (
		.clk(clk), .reset(reset), .button(clearAll), .press(clearPress)
	);

	buttonSync #(.debounceCycles(debounceCycles)) nextSync (
		.clk(clk), .reset(reset), .button(nextString), .press(nextPress)
	);

	messageSequencer sequencer0 (
		.clk(clk), .reset(reset), .clearAll(clearPress), .nextString(nextPress),
		.link(link.sequencer)
	);

	lcdNibbleDriver #(
		.powerOnCycles(powerOnCycles),
		.setupCycles(setupCycles),
		.enableCycles(enableCycles),
		.shortWaitCycles(shortWaitCycles),
		.longWaitCycles(longWaitCycles)
	) driver0 (
		.clk(clk), .reset(reset), .link(link.driver),
		.lcdRs(lcdRs), .lcdRw(lcdRw), .lcdE(lcdE), .lcdData(lcdData)
	);

endmodule

//--- bench/lcdMonitor.sv
`timescale 1ns/1ps

module lcdMonitor (
	input logic       lcdRs,
	input logic       lcdRw,
	input logic       lcdE,
	input logic [3:0] lcdData
);

	lcdPkg::lcdByte expQ [$];

	int         mismatchErrors = 0;
	int         unexpectedErrors = 0;
	int         busErrors = 0;
	int         initNibbles = 0;	// power-on nibbles seen so far.
	logic       haveHigh = 1'b0;
	logic       highRs;
	logic [3:0] highNibble;
	logic       armed = 1'b0;	// e has been high since the last fall.
	logic       moved = 1'b0;
	logic       rsAtRise;
	logic [3:0] dataAtRise;

	task automatic expectByte(input lcdPkg::lcdByte b);
		expQ.push_back(b);
	endtask

	function automatic int pendingCount();
		return expQ.size();
	endfunction

	task automatic checkByte(input lcdPkg::lcdByte got);
		lcdPkg::lcdByte want;
		if (expQ.size() == 0) begin
			unexpectedErrors++;
			$display("Unexpected LCD write at %0t ns: rs %0d value 0x%02h, nothing was expected",
				$time, got.kind, got.value);
		end else begin
			want = expQ.pop_front();
			if (got !== want) begin
				mismatchErrors++;
				$display("Fail at %0t ns: expected rs %0d value 0x%02h, got rs %0d value 0x%02h",
					$time, want.kind, want.value, got.kind, got.value);
			end
		end
	endtask

	// ------------------------------------------------------------------
	// bus watch
	// ------------------------------------------------------------------

	always @(posedge lcdE) begin
		armed      = (lcdE === 1'b1);
		moved      = 1'b0;
		rsAtRise   = lcdRs;
		dataAtRise = lcdData;
	end

	always @(lcdRs or lcdData) begin
		if (lcdE === 1'b1) moved = 1'b1;	// rs or data changed while e high.
	end

	always @(negedge lcdE) begin
		lcdPkg::lcdByte got;
		logic [3:0]     wantNibble;
		if (armed) begin
			armed = 1'b0;
			if (lcdRw !== 1'b0 || moved || lcdRs !== rsAtRise || lcdData !== dataAtRise) begin
				busErrors++;
				$display("Bus rule broken at %0t ns: rw %b, rs or data not stable while E high",
					$time, lcdRw);
			end
			if (initNibbles < 4) begin
				wantNibble = (initNibbles < 3) ? 4'h3 : 4'h2;	// last one selects 4-bit bus.
				if (lcdRs !== 1'b0 || lcdData !== wantNibble) begin
					mismatchErrors++;
					$display("Fail at %0t ns: init nibble %0d expected 0x%h, got rs %0d data 0x%h",
						$time, initNibbles, wantNibble, lcdRs, lcdData);
				end
				initNibbles++;
			end else if (!haveHigh) begin
				highRs     = lcdRs;
				highNibble = lcdData;
				haveHigh   = 1'b1;
			end else begin
				haveHigh  = 1'b0;
				got.kind  = lcdPkg::lcdByteKind'(highRs);
				got.value = {highNibble, lcdData};
				checkByte(got);
			end
		end
	end

endmodule

//--- bench/lcdTb.sv
`timescale 1ns/1ps

module lcdTb;

	localparam int debounceCycles  = 8;
	localparam int powerOnCycles   = 40;
	localparam int setupCycles     = 2;
	localparam int enableCycles    = 3;
	localparam int shortWaitCycles = 10;
	localparam int longWaitCycles  = 30;
	localparam int quietCycles     = 100;	// watch time for rows that expect no write.
	localparam int rowCount        = 8;

	typedef enum logic [1:0] {actNone, actNext, actClear, actGlitch} actionKind;
	typedef enum logic [1:0] {listNone, listInit, listClear, listMessage} listKind;

	typedef struct packed {
		actionKind  action;
		logic [7:0] hold;
		listKind    list;
	} stimRow;

	// ------------------------------------------------------------------
	// stimulus table
	// ------------------------------------------------------------------

	stimRow rows [rowCount] = '{
		'{actNone,   8'd0,  listInit},
		'{actNone,   8'd0,  listMessage},
		'{actNext,   8'd20, listMessage},
		'{actClear,  8'd20, listClear},
		'{actNext,   8'd20, listMessage},
		'{actNext,   8'd20, listMessage},
		'{actGlitch, 8'd3,  listNone},
		'{actNext,   8'd20, listMessage}
	};

	string rowNames [rowCount] = '{
		"powerOnInit", "firstMessage", "nextToOne", "clearOnly",
		"nextAfterClear", "nextToOneAgain", "glitchNext", "backToZero"
	};

	logic       clk;
	logic       reset;
	logic       clearAll;
	logic       nextString;
	logic       lcdRs;
	logic       lcdRw;
	logic       lcdE;
	logic [3:0] lcdData;
	logic       msgIdx;
	int         listLen;
	int         errorTotal;
	int         limitCycles;
	string      currentRow = "reset";

	lcdTop #(
		.debounceCycles(debounceCycles),
		.powerOnCycles(powerOnCycles),
		.setupCycles(setupCycles),
		.enableCycles(enableCycles),
		.shortWaitCycles(shortWaitCycles),
		.longWaitCycles(longWaitCycles)
	) dut0 (
		.clk(clk), .reset(reset), .clearAll(clearAll), .nextString(nextString),
		.lcdRs(lcdRs), .lcdRw(lcdRw), .lcdE(lcdE), .lcdData(lcdData)
	);

	lcdMonitor monitor0 (.lcdRs(lcdRs), .lcdRw(lcdRw), .lcdE(lcdE), .lcdData(lcdData));

	function automatic lcdPkg::lcdByte makeByte(input lcdPkg::lcdByteKind k, input logic [7:0] v);
		lcdPkg::lcdByte b;
		b.kind  = k;
		b.value = v;
		return b;
	endfunction

	function automatic int byteTime(input int waitCycles);
		return 2 * (setupCycles + 2 * enableCycles) + waitCycles + 2;	// 2 cycles margin.
	endfunction

	function automatic int runLimit();
		int total;
		total = 16 + powerOnCycles + 4 * (setupCycles + 2 * enableCycles + longWaitCycles + 2);
		total += byteTime(longWaitCycles) + 3 * byteTime(shortWaitCycles);
		for (int i = 0; i < rowCount; i++) begin
			total += 2 * rows[i].hold + debounceCycles + 3 + quietCycles + byteTime(longWaitCycles);
			if (rows[i].list == listMessage) begin
				total += byteTime(longWaitCycles) + 17 * byteTime(shortWaitCycles);
			end else if (rows[i].list == listClear) begin
				total += byteTime(longWaitCycles);
			end
		end
		return total;
	endfunction

	task automatic queueList(input listKind k, input logic idx, output int n);
		n = 0;
		if (k == listInit) begin
			monitor0.expectByte(makeByte(lcdPkg::kindCmd, lcdPkg::cmdFunctionSet));
			monitor0.expectByte(makeByte(lcdPkg::kindCmd, lcdPkg::cmdDisplayOn));
			monitor0.expectByte(makeByte(lcdPkg::kindCmd, lcdPkg::cmdEntryMode));
			monitor0.expectByte(makeByte(lcdPkg::kindCmd, lcdPkg::cmdClear));
			n = 4;
		end else if (k != listNone) begin
			monitor0.expectByte(makeByte(lcdPkg::kindCmd, lcdPkg::cmdClear));
			n = 1;
			if (k == listMessage) begin
				monitor0.expectByte(makeByte(lcdPkg::kindCmd, lcdPkg::cmdHome));
				for (int c = 0; c < lcdPkg::msgLength; c++) begin
					monitor0.expectByte(makeByte(lcdPkg::kindChar, lcdPkg::msgTable[idx][c]));
				end
				n += 1 + lcdPkg::msgLength;
			end
		end
	endtask

	task automatic applyAction(input actionKind a, input int hold);
		if (a != actNone) begin
			@(negedge clk);
			if (a == actClear) clearAll = 1'b1;
			else nextString = 1'b1;	// glitch goes on the next button.
			repeat (hold) @(negedge clk);
			clearAll   = 1'b0;
			nextString = 1'b0;
			repeat (hold) @(negedge clk);	// let the released level settle.
		end
	endtask

	// ------------------------------------------------------------------
	// clock, watchdog, main loop
	// ------------------------------------------------------------------

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		limitCycles = runLimit();
		repeat (limitCycles) @(posedge clk);
		$display("Timeout: run did not finish within %0d cycles, stuck in row %s",
			limitCycles, currentRow);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		reset      = 1'b1;
		clearAll   = 1'b0;
		nextString = 1'b0;
		msgIdx     = 1'b0;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < rowCount; i++) begin
			currentRow = rowNames[i];
			if (rows[i].action == actNext) msgIdx = ~msgIdx;
			queueList(rows[i].list, msgIdx, listLen);
			applyAction(rows[i].action, rows[i].hold);
			while (monitor0.pendingCount() != 0) @(negedge clk);
			if (listLen == 0) repeat (quietCycles) @(negedge clk);
		end
		errorTotal = monitor0.mismatchErrors + monitor0.unexpectedErrors + monitor0.busErrors;
		$display("Errors: %0d mismatched, %0d unexpected writes, %0d bus rule",
			monitor0.mismatchErrors, monitor0.unexpectedErrors, monitor0.busErrors);
		if (errorTotal == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- sim.f
verilog/lcdPkg.sv
verilog/lcdCmdIf.sv
verilog/buttonSync.sv
verilog/messageSequencer.sv
verilog/lcdNibbleDriver.sv
verilog/lcdTop.sv
bench/lcdMonitor.sv
bench/lcdTb.sv
